// File: source/dma_rd_pkg.sv
// ***********************************************************
// Read DMA shared types
// Command, burst descriptor, AXI read channel and status
// structs with the AXI constants used across the engine
// ***********************************************************

package dma_rd_pkg;

    // AXI4 burst length field width
    localparam int AXI_LEN_WIDTH = 8;

    // Bursts may not cross this address boundary
    localparam int AXI_BOUNDARY_BYTES = 4096;

    // Beat size code for a 32-bit data bus
    localparam logic [2:0] AXI_SIZE_WORD = 3'd2;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } dma_resp_e;

    // AXI burst type encoding
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01
    } dma_burst_e;

    // Host command
    typedef struct packed {
        logic [31:0] addr;
        logic [15:0] byte_len;
        logic        fixed;
    } dma_cmd_t;

    // One AXI-legal burst, len is beats minus one
    typedef struct packed {
        logic [31:0]              addr;
        logic [AXI_LEN_WIDTH-1:0] len;
        logic                     fixed;
        logic                     last;
    } dma_burst_t;

    typedef struct packed {
        logic [31:0] araddr;
        logic [7:0]  arlen;
        logic [2:0]  arsize;
        dma_burst_e  arburst;
        logic        arid;
    } axi_ar_t;

    // Data width fixed at 32 bits
    typedef struct packed {
        logic [31:0] rdata;
        dma_resp_e   rresp;
        logic        rlast;
    } axi_r_t;

    typedef struct packed {
        dma_resp_e resp;
        logic      error;
    } dma_status_t;

endpackage

// File: source/dma_cmd_intake.sv
// ***********************************************************
// Read DMA command intake
// Four-phase host handshake, command hold and the OR of
// burst responses into one completion status
// ***********************************************************
`timescale 1ns/1ps

module dma_cmd_intake import dma_rd_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_cmd_req,
    input  dma_cmd_t    i_cmd,
    output logic        o_cmd_ack,
    output logic        o_cmd_valid,
    output dma_cmd_t    o_cmd,
    input  logic        i_cmd_ready,
    input  logic        i_burst_done,
    input  dma_resp_e   i_burst_resp,
    input  logic        i_burst_last,
    output logic        o_status_valid,
    output dma_status_t o_status
);

    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_DROP,
        BUSY
    } state_e;

    state_e    state;
    state_e    state_nxt;
    dma_cmd_t  cmd_q;
    logic      cmd_pend;
    dma_resp_e resp_acc;
    logic      capture;
    logic      done_last;

    assign capture   = (state == IDLE) && i_cmd_req;
    assign done_last = i_burst_done && i_burst_last;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (i_cmd_req) begin
                    state_nxt = ACK;
                end
            end
            ACK: begin
                // Command may finish before the host drops req
                if (!i_cmd_req) begin
                    state_nxt = done_last ? IDLE : BUSY;
                end else if (done_last) begin
                    state_nxt = WAIT_DROP;
                end
            end
            WAIT_DROP: begin
                if (!i_cmd_req) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                if (done_last) begin
                    state_nxt = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= IDLE;
            cmd_pend       <= 1'b0;
            resp_acc       <= OKAY;
            o_status_valid <= 1'b0;
        end else begin
            state          <= state_nxt;
            o_status_valid <= done_last;
            // Hand the command to the splitter once
            if (capture) begin
                cmd_pend <= 1'b1;
            end else if (i_cmd_ready) begin
                cmd_pend <= 1'b0;
            end
            if (capture) begin
                resp_acc <= OKAY;
            end else if (i_burst_done) begin
                resp_acc <= dma_resp_e'(resp_acc | i_burst_resp);
            end
        end
    end

    // Command payload held for the whole transfer
    always_ff @(posedge clk) begin
        if (capture) begin
            cmd_q <= i_cmd;
        end
    end

    assign o_cmd_ack       = (state == ACK) || (state == WAIT_DROP);
    assign o_cmd_valid     = cmd_pend;
    assign o_cmd           = cmd_q;
    // SLVERR and DECERR both carry the high bit
    assign o_status.resp   = resp_acc;
    assign o_status.error  = resp_acc[1];

    // Only word-aligned, nonzero commands are supported
    assert property (@(posedge clk) disable iff (!rst_n)
        capture |-> (i_cmd.addr[1:0] == 2'b00) && (i_cmd.byte_len[1:0] == 2'b00)
                    && (i_cmd.byte_len != 16'd0));

    // Final burst only returns while a command is open
    assert property (@(posedge clk) disable iff (!rst_n)
        done_last |-> (state == ACK) || (state == BUSY));

endmodule

// File: source/dma_burst_split.sv
// ***********************************************************
// Read DMA burst splitter
// Cuts a command into bursts that respect the beat limit
// and never cross a 4 KB page
// ***********************************************************
`timescale 1ns/1ps

module dma_burst_split import dma_rd_pkg::*; #(
    parameter int MAX_BURST_BEATS = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_cmd_valid,
    input  dma_cmd_t   i_cmd,
    output logic       o_cmd_ready,
    output logic       o_burst_valid,
    output dma_burst_t o_burst,
    input  logic       i_burst_ready
);

    // Address bits inside one page
    localparam int PAGE_W = $clog2(AXI_BOUNDARY_BYTES);

    logic              busy;
    logic [31:0]       rem_addr;
    logic [15:0]       rem_words;
    logic              rem_fixed;
    logic [PAGE_W:0]   page_bytes;
    logic [15:0]       page_words;
    logic [15:0]       cap;
    logic [15:0]       beats;
    logic              cmd_fire;
    logic              burst_fire;

    assign cmd_fire   = i_cmd_valid && o_cmd_ready;
    assign burst_fire = o_burst_valid && i_burst_ready;

    // Beat count of the next burst
    always_comb begin
        page_bytes = (PAGE_W + 1)'(AXI_BOUNDARY_BYTES) - {1'b0, rem_addr[PAGE_W-1:0]};
        page_words = 16'(page_bytes >> 2);
        cap        = 16'(MAX_BURST_BEATS);
        // Fixed bursts stay on one address, page limit does not apply
        if (!rem_fixed && (page_words < cap)) begin
            cap = page_words;
        end
        beats = (rem_words < cap) ? rem_words : cap;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (cmd_fire) begin
            busy <= 1'b1;
        end else if (burst_fire && o_burst.last) begin
            busy <= 1'b0;
        end
    end

    // Remaining work, no reset needed behind busy
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            rem_addr  <= i_cmd.addr;
            rem_words <= {2'b00, i_cmd.byte_len[15:2]};
            rem_fixed <= i_cmd.fixed;
        end else if (burst_fire) begin
            rem_words <= rem_words - beats;
            if (!rem_fixed) begin
                rem_addr <= rem_addr + 32'({beats, 2'b00});
            end
        end
    end

    assign o_cmd_ready   = !busy;
    assign o_burst_valid = busy;

    always_comb begin
        o_burst.addr  = rem_addr;
        o_burst.len   = AXI_LEN_WIDTH'(beats - 16'd1);
        o_burst.fixed = rem_fixed;
        // Last burst takes every remaining word
        o_burst.last  = (rem_words == beats);
    end

    // Incrementing bursts end at or before the page edge
    assert property (@(posedge clk) disable iff (!rst_n)
        o_burst_valid && !o_burst.fixed |->
            (14'(o_burst.addr[PAGE_W-1:0]) + 14'({o_burst.len, 2'b00}) + 14'd4)
            <= 14'(AXI_BOUNDARY_BYTES));

endmodule

// File: source/axi_mgr_rd.sv
// ***********************************************************
// AXI4 read manager
// Issues AR from a two-entry descriptor buffer, passes R beats
// on and reports the ORed response of each burst
// ***********************************************************
`timescale 1ns/1ps

module axi_mgr_rd import dma_rd_pkg::*; #(
    parameter int MAX_BURST_BEATS = 16
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_burst_valid,
    input  dma_burst_t  i_burst,
    output logic        o_burst_ready,
    output logic        o_ar_valid,
    output axi_ar_t     o_ar,
    input  logic        i_ar_ready,
    input  logic        i_r_valid,
    input  axi_r_t      i_r,
    output logic        o_r_ready,
    input  logic        i_fifo_ready,
    output logic        o_beat_valid,
    output logic [31:0] o_beat_data,
    output logic        o_burst_done,
    output dma_resp_e   o_burst_resp,
    output logic        o_burst_last
);

    // Skid buffer, out entry feeds AR
    logic       out_valid;
    dma_burst_t out_q;
    logic       skid_valid;
    dma_burst_t skid_q;

    logic       ctx_ready;
    logic       ctx_pop;
    logic       sent;
    logic       txn_active;
    logic       txn_last;
    logic       beat_acc;
    logic       final_beat;
    dma_resp_e  resp_acc;

    assign o_burst_ready = !skid_valid;
    assign ctx_pop       = out_valid && ctx_ready;

    // Pop once the AR is out and the previous burst is draining its last beat
    assign ctx_ready = (!txn_active || final_beat) && (i_ar_ready || sent);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (ctx_ready || !out_valid) begin
            out_valid  <= skid_valid || i_burst_valid;
            skid_valid <= 1'b0;
        end else if (i_burst_valid && o_burst_ready) begin
            // Out entry stalled, park the incoming one
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ctx_ready || !out_valid) begin
            out_q <= skid_valid ? skid_q : i_burst;
        end
        if (!(ctx_ready || !out_valid) && i_burst_valid && o_burst_ready) begin
            skid_q <= i_burst;
        end
    end

    // AR already issued for the out entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sent <= 1'b0;
        end else if (ctx_pop) begin
            sent <= 1'b0;
        end else if (o_ar_valid && i_ar_ready) begin
            sent <= 1'b1;
        end
    end

    always_comb begin
        o_ar_valid     = out_valid && !sent;
        o_ar.araddr    = out_q.addr;
        o_ar.arlen     = out_q.len;
        o_ar.arsize    = AXI_SIZE_WORD;
        o_ar.arburst   = out_q.fixed ? FIXED : INCR;
        o_ar.arid      = 1'b0;
    end

    // Burst whose data is returning
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txn_active <= 1'b0;
            txn_last   <= 1'b0;
            resp_acc   <= OKAY;
        end else begin
            if (ctx_pop) begin
                txn_active <= 1'b1;
                txn_last   <= out_q.last;
            end else if (final_beat) begin
                txn_active <= 1'b0;
            end
            // Fresh response for every burst
            if (final_beat) begin
                resp_acc <= OKAY;
            end else if (beat_acc) begin
                resp_acc <= dma_resp_e'(resp_acc | i_r.rresp);
            end
        end
    end

    assign o_r_ready  = txn_active && i_fifo_ready;
    assign beat_acc   = i_r_valid && o_r_ready;
    assign final_beat = beat_acc && i_r.rlast;

    // Beats go to the FIFO in the cycle they are accepted
    assign o_beat_valid = beat_acc;
    assign o_beat_data  = i_r.rdata;

    assign o_burst_done = final_beat;
    assign o_burst_resp = dma_resp_e'(resp_acc | i_r.rresp);
    assign o_burst_last = txn_last;

    // Returning data always belongs to a popped burst
    assert property (@(posedge clk) disable iff (!rst_n)
        i_r_valid |-> txn_active);

    // Splitter keeps every burst within the beat limit
    assert property (@(posedge clk) disable iff (!rst_n)
        o_ar_valid |-> (int'(o_ar.arlen) < MAX_BURST_BEATS));

endmodule

// File: source/dma_rd_fifo.sv
// ***********************************************************
// Read data FIFO
// Register array with wrap-bit pointers, valid/ready on
// both sides
// ***********************************************************
`timescale 1ns/1ps

module dma_rd_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_wr_valid,
    input  logic [31:0] i_wr_data,
    output logic        o_wr_ready,
    output logic        o_rd_valid,
    output logic [31:0] o_rd_data,
    input  logic        i_rd_ready
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [31:0]    mem [FIFO_DEPTH];
    // Top bit is the wrap flag
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           full;
    logic           empty;
    logic           wr_en;
    logic           rd_en;

    assign empty = (wr_ptr == rd_ptr);
    // Same slot, opposite wrap
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W])
                   && (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign wr_en = i_wr_valid && o_wr_ready;
    assign rd_en = o_rd_valid && i_rd_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[PTR_W-1:0]] <= i_wr_data;
        end
    end

    assign o_wr_ready = !full;
    assign o_rd_valid = !empty;
    assign o_rd_data  = mem[rd_ptr[PTR_W-1:0]];

    // Manager holds off R when the FIFO is full
    assert property (@(posedge clk) disable iff (!rst_n)
        i_wr_valid |-> !full);

endmodule

// File: source/dma_rd_top.sv
// ***********************************************************
// Read DMA engine top level
// Intake, burst splitter, AXI read manager and data FIFO
// ***********************************************************
`timescale 1ns/1ps

module dma_rd_top import dma_rd_pkg::*; #(
    parameter int MAX_BURST_BEATS = 16,
    parameter int FIFO_DEPTH      = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_cmd_req,
    input  dma_cmd_t    i_cmd,
    output logic        o_cmd_ack,
    output logic        o_ar_valid,
    output axi_ar_t     o_ar,
    input  logic        i_ar_ready,
    input  logic        i_r_valid,
    input  axi_r_t      i_r,
    output logic        o_r_ready,
    output logic        o_data_valid,
    output logic [31:0] o_data,
    input  logic        i_data_ready,
    output logic        o_status_valid,
    output dma_status_t o_status
);

    // Intake to splitter
    logic        cmd_valid;
    dma_cmd_t    cmd;
    logic        cmd_ready;
    // Splitter to manager
    logic        burst_valid;
    dma_burst_t  burst;
    logic        burst_ready;
    // Manager to FIFO and intake
    logic        fifo_ready;
    logic        beat_valid;
    logic [31:0] beat_data;
    logic        burst_done;
    dma_resp_e   burst_resp;
    logic        burst_last;

    dma_cmd_intake u_intake (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_cmd_req      (i_cmd_req),
        .i_cmd          (i_cmd),
        .o_cmd_ack      (o_cmd_ack),
        .o_cmd_valid    (cmd_valid),
        .o_cmd          (cmd),
        .i_cmd_ready    (cmd_ready),
        .i_burst_done   (burst_done),
        .i_burst_resp   (burst_resp),
        .i_burst_last   (burst_last),
        .o_status_valid (o_status_valid),
        .o_status       (o_status)
    );

    dma_burst_split #(
        .MAX_BURST_BEATS (MAX_BURST_BEATS)
    ) u_split (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_cmd_valid   (cmd_valid),
        .i_cmd         (cmd),
        .o_cmd_ready   (cmd_ready),
        .o_burst_valid (burst_valid),
        .o_burst       (burst),
        .i_burst_ready (burst_ready)
    );

    axi_mgr_rd #(
        .MAX_BURST_BEATS (MAX_BURST_BEATS)
    ) u_mgr (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_burst_valid (burst_valid),
        .i_burst       (burst),
        .o_burst_ready (burst_ready),
        .o_ar_valid    (o_ar_valid),
        .o_ar          (o_ar),
        .i_ar_ready    (i_ar_ready),
        .i_r_valid     (i_r_valid),
        .i_r           (i_r),
        .o_r_ready     (o_r_ready),
        .i_fifo_ready  (fifo_ready),
        .o_beat_valid  (beat_valid),
        .o_beat_data   (beat_data),
        .o_burst_done  (burst_done),
        .o_burst_resp  (burst_resp),
        .o_burst_last  (burst_last)
    );

    dma_rd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_wr_valid (beat_valid),
        .i_wr_data  (beat_data),
        .o_wr_ready (fifo_ready),
        .o_rd_valid (o_data_valid),
        .o_rd_data  (o_data),
        .i_rd_ready (i_data_ready)
    );

endmodule

// File: verification/tb_dma_rd_top.sv
// ***********************************************************
// Read DMA engine testbench
// AXI read memory model, command table and checks on data,
// burst legality and completion status
// ***********************************************************
`timescale 1ns/1ps

module tb_dma_rd_top import dma_rd_pkg::*; ();

    localparam int          MAX_BEATS  = 16;
    localparam int          FIFO_DEPTH = 8;
    localparam int          ACK_LIMIT  = 50;
    localparam int          DONE_LIMIT = 5000;
    localparam logic [31:0] SEED       = 32'h514c0194;
    // Memory content is address XOR key
    localparam logic [31:0] DATA_KEY   = 32'h5A5A_C3C3;
    // Reads in this window answer SLVERR
    localparam logic [31:0] ERR_LO     = 32'h0000_8000;
    localparam logic [31:0] ERR_HI     = 32'h0000_8010;

    typedef struct {
        dma_cmd_t  cmd;
        dma_resp_e resp;
    } case_t;

    logic        clk;
    logic        rst_n;
    logic        i_cmd_req;
    dma_cmd_t    i_cmd;
    logic        o_cmd_ack;
    logic        o_ar_valid;
    axi_ar_t     o_ar;
    logic        i_ar_ready;
    logic        i_r_valid;
    axi_r_t      i_r;
    logic        o_r_ready;
    logic        o_data_valid;
    logic [31:0] o_data;
    logic        i_data_ready;
    logic        o_status_valid;
    dma_status_t o_status;

    case_t       cases[$];
    axi_ar_t     ar_q[$];
    logic [31:0] rx_q[$];
    int          beat_idx;
    bit          r_taken;
    bit          hold_data;
    dma_status_t status_got;
    int          status_seen;
    int          ack_rises;
    logic        ack_q;
    dma_cmd_t    cur_cmd;
    logic [31:0] next_ar_addr;
    int          ar_words;
    int          errors;
    int          tests_run;
    int          tests_failed;
    bit          aborted;

    dma_rd_top #(
        .MAX_BURST_BEATS (MAX_BEATS),
        .FIFO_DEPTH      (FIFO_DEPTH)
    ) i_dma_rd_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_cmd_req      (i_cmd_req),
        .i_cmd          (i_cmd),
        .o_cmd_ack      (o_cmd_ack),
        .o_ar_valid     (o_ar_valid),
        .o_ar           (o_ar),
        .i_ar_ready     (i_ar_ready),
        .i_r_valid      (i_r_valid),
        .i_r            (i_r),
        .o_r_ready      (o_r_ready),
        .o_data_valid   (o_data_valid),
        .o_data         (o_data),
        .i_data_ready   (i_data_ready),
        .o_status_valid (o_status_valid),
        .o_status       (o_status)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ DATA_KEY;
    endfunction

    function automatic bit in_err_window(input logic [31:0] addr);
        return (addr >= ERR_LO) && (addr < ERR_HI);
    endfunction

    task automatic add_case(input logic [31:0] addr, input int len, input bit fixed,
                            input dma_resp_e resp);
        case_t tc;
        tc.cmd.addr     = addr;
        tc.cmd.byte_len = 16'(len);
        tc.cmd.fixed    = fixed;
        tc.resp         = resp;
        cases.push_back(tc);
    endtask

    task automatic report_fail(input string msg);
        $display("FAIL @%0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic check_data(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp) begin
            report_fail($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_status(input dma_status_t got, input dma_status_t exp);
        if (got !== exp) begin
            report_fail($sformatf("status resp %0d error %0b expected resp %0d error %0b",
                                  got.resp, got.error, exp.resp, exp.error));
        end
    endtask

    // Legality of one accepted AR against the running command
    task automatic observe_ar(input axi_ar_t ar);
        int          beats;
        logic [31:0] end_addr;
        beats    = int'(ar.arlen) + 1;
        end_addr = ar.araddr + 32'(beats * 4) - 32'd1;
        if (beats > MAX_BEATS) begin
            report_fail($sformatf("AR with %0d beats exceeds the limit", beats));
        end
        check_data(32'(ar.arsize), 32'd2, "arsize");
        check_data(32'(ar.arid), 32'd0, "arid");
        if (cur_cmd.fixed) begin
            check_data(32'(ar.arburst), 32'(FIXED), "arburst");
            check_data(ar.araddr, cur_cmd.addr, "fixed araddr");
        end else begin
            check_data(32'(ar.arburst), 32'(INCR), "arburst");
            if (ar.araddr[31:12] !== end_addr[31:12]) begin
                report_fail($sformatf("AR at %h crosses a 4 KB page", ar.araddr));
            end
            check_data(ar.araddr, next_ar_addr, "araddr");
            next_ar_addr = ar.araddr + 32'(beats * 4);
        end
        ar_words += beats;
    endtask

    // Present the current beat of the oldest queued burst
    task automatic drive_beat();
        logic [31:0] addr;
        addr = ar_q[0].araddr;
        if (ar_q[0].arburst == INCR) begin
            addr = addr + 32'(beat_idx * 4);
        end
        i_r.rdata = mem_word(addr);
        i_r.rresp = in_err_window(addr) ? SLVERR : OKAY;
        i_r.rlast = (beat_idx == int'(ar_q[0].arlen));
        i_r_valid = 1'b1;
    endtask

    // Handshakes sampled before the flops update
    always @(posedge clk) begin
        if (rst_n) begin
            if (o_ar_valid && i_ar_ready) begin
                observe_ar(o_ar);
                ar_q.push_back(o_ar);
            end
            if (i_r_valid && o_r_ready) begin
                r_taken = 1'b1;
            end
            if (o_data_valid && i_data_ready) begin
                rx_q.push_back(o_data);
            end
            if (o_status_valid) begin
                status_got = o_status;
                status_seen++;
            end
            if (o_cmd_ack && !ack_q) begin
                ack_rises++;
            end
            ack_q = o_cmd_ack;
        end
    end

    // Memory model and consumer, random AR, R and data stalls
    always @(negedge clk) begin
        if (rst_n) begin
            i_ar_ready   = ($urandom % 4) != 0;
            i_data_ready = !hold_data && (($urandom % 3) != 0);
            if (r_taken) begin
                r_taken   = 1'b0;
                i_r_valid = 1'b0;
                if (beat_idx == int'(ar_q[0].arlen)) begin
                    void'(ar_q.pop_front());
                    beat_idx = 0;
                end else begin
                    beat_idx++;
                end
            end
            if (!i_r_valid && (ar_q.size() > 0) && (($urandom % 4) != 0)) begin
                drive_beat();
            end
        end
    end

    task automatic wait_ack(input logic level, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < ACK_LIMIT; n++) begin
            @(negedge clk);
            if (o_cmd_ack === level) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("Timeout: o_cmd_ack never went %0b", level);
            errors++;
        end
    endtask

    task automatic wait_done(input int words, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < DONE_LIMIT; n++) begin
            @(negedge clk);
            if ((status_seen > 0) && (rx_q.size() >= words)) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("Timeout: command ended with %0d of %0d words, %0d status",
                     rx_q.size(), words, status_seen);
            errors++;
        end
    endtask

    // Second request while busy, consumer held so the command cannot end
    task automatic probe_busy();
        @(posedge clk);
        hold_data = 1'b1;
        @(negedge clk);
        i_cmd_req = 1'b1;
        repeat (3) begin
            @(negedge clk);
            if (o_cmd_ack !== 1'b0) begin
                report_fail("o_cmd_ack raised while a command is busy");
            end
        end
        i_cmd_req = 1'b0;
        @(posedge clk);
        hold_data = 1'b0;
    endtask

    task automatic run_case(input int idx, input case_t tc);
        int          words;
        int          errs_before;
        bit          ok;
        logic [31:0] addr;
        dma_status_t exp_st;
        words        = int'(tc.cmd.byte_len) / 4;
        errs_before  = errors;
        cur_cmd      = tc.cmd;
        next_ar_addr = tc.cmd.addr;
        ar_words     = 0;
        rx_q.delete();
        status_seen  = 0;
        ack_rises    = 0;
        @(negedge clk);
        i_cmd     = tc.cmd;
        i_cmd_req = 1'b1;
        wait_ack(1'b1, ok);
        i_cmd_req = 1'b0;
        if (ok) begin
            wait_ack(1'b0, ok);
        end
        if (ok && (words >= 32)) begin
            probe_busy();
        end
        if (ok) begin
            wait_done(words, ok);
        end
        if (ok) begin
            // Let any stray extra word show up
            repeat (4) @(negedge clk);
            check_data(32'(ack_rises), 32'd1, "ack pulses");
            check_data(32'(rx_q.size()), 32'(words), "word count");
            check_data(32'(ar_words), 32'(words), "AR beats");
            check_data(32'(status_seen), 32'd1, "status pulses");
            for (int k = 0; (k < words) && (k < rx_q.size()); k++) begin
                addr = tc.cmd.fixed ? tc.cmd.addr : tc.cmd.addr + 32'(k * 4);
                check_data(rx_q[k], mem_word(addr), $sformatf("word %0d", k));
            end
            exp_st.resp  = tc.resp;
            exp_st.error = (tc.resp == SLVERR) || (tc.resp == DECERR);
            check_status(status_got, exp_st);
        end else begin
            aborted = 1'b1;
        end
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
        end
        $display("Test %0d addr %h len %0d %s: %s", idx, tc.cmd.addr, tc.cmd.byte_len,
                 tc.cmd.fixed ? "fixed" : "incr", (errors == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        void'($urandom(SEED));
        clk          = 1'b0;
        rst_n        = 1'b0;
        i_cmd_req    = 1'b0;
        i_cmd        = '0;
        i_ar_ready   = 1'b0;
        i_r_valid    = 1'b0;
        i_r          = '0;
        i_data_ready = 1'b0;
        hold_data    = 1'b0;
        r_taken      = 1'b0;
        beat_idx     = 0;
        ack_q        = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        // Address, bytes, fixed, expected resp
        add_case(32'h0000_1000, 64, 1'b0, OKAY);
        add_case(32'h0000_1FF0, 64, 1'b0, OKAY);
        add_case(32'h0000_3F00, 400, 1'b0, OKAY);
        add_case(32'h0000_2000, 80, 1'b1, OKAY);
        add_case(32'h0000_7FC0, 256, 1'b0, SLVERR);
        add_case(32'h0000_80F0, 32, 1'b0, OKAY);
        add_case(32'h0000_8008, 12, 1'b1, SLVERR);
        add_case(32'h0000_0FFC, 4, 1'b0, OKAY);
        add_case(32'h0001_0FC0, 512, 1'b0, OKAY);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Control outputs idle out of reset
        check_data(32'({o_cmd_ack, o_ar_valid, o_r_ready, o_data_valid, o_status_valid}),
                   32'd0, "control outputs after reset");
        for (int i = 0; (i < cases.size()) && !aborted; i++) begin
            run_case(i, cases[i]);
        end
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if ((errors == 0) && !aborted) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: dma_rd_top.f
source/dma_rd_pkg.sv
source/dma_cmd_intake.sv
source/dma_burst_split.sv
source/axi_mgr_rd.sv
source/dma_rd_fifo.sv
source/dma_rd_top.sv
verification/tb_dma_rd_top.sv

// File: Bender.yml
package:
  name: dma_rd

sources:
  # Shared types first
  - source/dma_rd_pkg.sv
  # Pipeline stages
  - source/dma_cmd_intake.sv
  - source/dma_burst_split.sv
  - source/axi_mgr_rd.sv
  - source/dma_rd_fifo.sv
  # Top level
  - source/dma_rd_top.sv
  # Testbench
  - target: test
    files:
      - verification/tb_dma_rd_top.sv
